/* hdl/cgra_pkg.sv */
package cgra_pkg;

    // ----------------------------------------------------------------------
    // Sizes
    // ----------------------------------------------------------------------
    localparam int CTX_WIDTH      = 64;
    localparam int CTX_DEPTH      = 16;
    localparam int CTX_ROW_BITS   = $clog2(CTX_DEPTH);
    localparam int LANE_BITS      = $clog2(CTX_WIDTH / 16);
    localparam int APB_ADDR_WIDTH = 20;
    localparam int APB_DATA_WIDTH = 32;
    localparam int APB_STRB_WIDTH = APB_DATA_WIDTH / 8;
    localparam int MAX_TILES      = 64;
    localparam int TILE_BITS      = $clog2(MAX_TILES);

    // Address field positions (LSB of each field)
    localparam int REGION_LSB = 18;
    localparam int TILE_LSB   = 7;
    localparam int ROW_LSB    = 3;
    localparam int LANE_LSB   = 1;
    localparam int REG_LSB    = 2;

    // ----------------------------------------------------------------------
    // Encodings
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        region_ctx    = 2'd0,
        region_ctrl   = 2'd1,
        region_status = 2'd2,
        region_bad    = 2'd3
    } region_e;

    typedef enum logic [1:0] {
        reg_run        = 2'd0,
        reg_loop_start = 2'd1,
        reg_loop_end   = 2'd2
    } ctrl_reg_e;

    // Only jump is decoded, all other codes act as nop
    typedef enum logic [4:0] {
        op_nop  = 5'b00000,
        op_jump = 5'b11110
    } ctx_opcode_e;

    typedef struct packed {
        logic [17:0] spare_hi;
        logic [2:0]  jump_target;
        logic [7:0]  spare_mid;
        ctx_opcode_e opcode;
        logic [29:0] spare_lo;
    } ctx_word_t;

    typedef struct packed {
        logic                    write;
        logic [CTX_ROW_BITS-1:0] row;
        logic [LANE_BITS-1:0]    lane;
        logic [15:0]             data;
        logic [1:0]              strb;
    } ctx_access_t;

    typedef struct packed {
        logic [CTX_ROW_BITS-1:0] loop_start;
        logic [CTX_ROW_BITS-1:0] loop_end;
    } loop_cfg_t;

endpackage

/* hdl/context_memory.sv */
`timescale 1ns/1ps

module context_memory (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              wr_en,
    input  cgra_pkg::ctx_access_t             access,
    input  logic [cgra_pkg::CTX_ROW_BITS-1:0] pc,
    output cgra_pkg::ctx_word_t               pc_word,
    output cgra_pkg::ctx_word_t               host_word
);

    logic [cgra_pkg::CTX_WIDTH-1:0] mem [cgra_pkg::CTX_DEPTH];
    logic [cgra_pkg::CTX_WIDTH-1:0] bit_mask;
    logic [cgra_pkg::CTX_WIDTH-1:0] wr_data;

    // ----------------------------------------------------------------------
    // Lane and byte strobes to a bit mask
    // ----------------------------------------------------------------------
    always_comb begin
        bit_mask = '0;
        wr_data  = '0;
        bit_mask[{access.lane, 4'b0000} +: 8]      = {8{access.strb[0]}};
        bit_mask[{access.lane, 4'b1000} +: 8]      = {8{access.strb[1]}};
        wr_data[{access.lane, 4'b0000} +: 16]      = access.data;
    end

    // Merge the halfword into the addressed row
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < cgra_pkg::CTX_DEPTH; r++) begin
                mem[r] <= '0;
            end
        end else if (wr_en) begin
            mem[access.row] <= (mem[access.row] & ~bit_mask) | (wr_data & bit_mask);
        end
    end

    // ----------------------------------------------------------------------
    // Read ports
    // ----------------------------------------------------------------------
    // Sequencer side
    assign pc_word   = cgra_pkg::ctx_word_t'(mem[pc]);

    // Host readback side
    assign host_word = cgra_pkg::ctx_word_t'(mem[access.row]);

endmodule

/* hdl/cgra_tile.sv */
`timescale 1ns/1ps

module cgra_tile (
    input  logic                              clk,
    input  logic                              reset,
    input  cgra_pkg::ctx_access_t             ctx_access,
    input  logic                              sel,
    input  cgra_pkg::loop_cfg_t               loop_cfg,
    input  logic                              run,
    output cgra_pkg::ctx_word_t               host_word,
    output logic [cgra_pkg::CTX_ROW_BITS-1:0] pc
);

    cgra_pkg::ctx_word_t   pc_word;
    cgra_pkg::ctx_opcode_e prev_op;
    logic                  wr_en;
    logic                  take_jump;
    logic                  out_of_window;

    // ----------------------------------------------------------------------
    // Context store
    // ----------------------------------------------------------------------
    assign wr_en = sel & ctx_access.write;

    context_memory u_ctx_mem (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .access    (ctx_access),
        .pc        (pc),
        .pc_word   (pc_word),
        .host_word (host_word)
    );

    // ----------------------------------------------------------------------
    // Loop sequencer
    // ----------------------------------------------------------------------
    // No back-to-back jumps
    assign take_jump = (pc_word.opcode == cgra_pkg::op_jump) &&
                       (prev_op != cgra_pkg::op_jump);

    // End is inclusive, start <= end is up to software
    assign out_of_window = (pc >= loop_cfg.loop_end) || (pc < loop_cfg.loop_start);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (run) begin
            if (take_jump) begin
                pc <= cgra_pkg::CTX_ROW_BITS'(pc_word.jump_target);
            end else if (out_of_window) begin
                pc <= loop_cfg.loop_start;
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

    // Previous opcode starts each run as nop
    always_ff @(posedge clk) begin
        if (reset) begin
            prev_op <= cgra_pkg::op_nop;
        end else if (run) begin
            prev_op <= pc_word.opcode;
        end else begin
            prev_op <= cgra_pkg::op_nop;
        end
    end

endmodule

/* hdl/cfg_apb_slave.sv */
`timescale 1ns/1ps

module cfg_apb_slave #(
    parameter int NUM_TILES = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [cgra_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic [cgra_pkg::APB_DATA_WIDTH-1:0] pwdata,
    input  logic [cgra_pkg::APB_STRB_WIDTH-1:0] pstrb,
    input  cgra_pkg::ctx_word_t                 tile_word [NUM_TILES],
    input  logic [cgra_pkg::CTX_ROW_BITS-1:0]   tile_pc [NUM_TILES],
    output logic [cgra_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr,
    output cgra_pkg::ctx_access_t               ctx_access,
    output logic [NUM_TILES-1:0]                tile_sel,
    output cgra_pkg::loop_cfg_t                 loop_cfg,
    output logic                                run
);

    cgra_pkg::region_e                 region;
    cgra_pkg::ctrl_reg_e               reg_sel;
    logic [cgra_pkg::TILE_BITS-1:0]    tile_idx;
    logic                              access;
    logic                              tile_valid;
    logic                              err;
    logic                              ctrl_wr;
    cgra_pkg::ctx_word_t               sel_word;
    logic [cgra_pkg::CTX_ROW_BITS-1:0] sel_pc;
    logic [15:0]                       sel_half;

    // ----------------------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------------------
    assign region     = cgra_pkg::region_e'(paddr[cgra_pkg::REGION_LSB +: 2]);
    assign reg_sel    = cgra_pkg::ctrl_reg_e'(paddr[cgra_pkg::REG_LSB +: 2]);
    assign tile_idx   = paddr[cgra_pkg::TILE_LSB +: cgra_pkg::TILE_BITS];
    assign access     = psel & penable;
    assign tile_valid = (tile_idx < NUM_TILES);

    // One-hot select plus the returned word and pc of the addressed tile
    always_comb begin
        tile_sel = '0;
        sel_word = '0;
        sel_pc   = '0;
        for (int t = 0; t < NUM_TILES; t++) begin
            if (tile_idx == t) begin
                tile_sel[t] = (region == cgra_pkg::region_ctx);
                sel_word    = tile_word[t];
                sel_pc      = tile_pc[t];
            end
        end
    end

    always_comb begin
        case (region)
            cgra_pkg::region_ctx:    err = !tile_valid || run;
            cgra_pkg::region_status: err = !tile_valid;
            cgra_pkg::region_bad:    err = 1'b1;
            default:                 err = 1'b0;
        endcase
    end

    assign pslverr = access & err;
    assign pready  = 1'b1;

    // ----------------------------------------------------------------------
    // Context access to the tiles
    // ----------------------------------------------------------------------
    assign ctx_access.write = access & pwrite & ~err & (region == cgra_pkg::region_ctx);
    assign ctx_access.row   = paddr[cgra_pkg::ROW_LSB +: cgra_pkg::CTX_ROW_BITS];
    assign ctx_access.lane  = paddr[cgra_pkg::LANE_LSB +: cgra_pkg::LANE_BITS];
    assign ctx_access.data  = pwdata[15:0];
    assign ctx_access.strb  = pstrb[1:0];

    // ----------------------------------------------------------------------
    // Control registers
    // ----------------------------------------------------------------------
    assign ctrl_wr = access & pwrite & pstrb[0] & (region == cgra_pkg::region_ctrl);

    always_ff @(posedge clk) begin
        if (reset) begin
            run      <= 1'b0;
            loop_cfg <= '0;
        end else if (ctrl_wr) begin
            case (reg_sel)
                cgra_pkg::reg_run: begin
                    run <= pwdata[0];
                end
                cgra_pkg::reg_loop_start: begin
                    loop_cfg.loop_start <= pwdata[cgra_pkg::CTX_ROW_BITS-1:0];
                end
                cgra_pkg::reg_loop_end: begin
                    loop_cfg.loop_end <= pwdata[cgra_pkg::CTX_ROW_BITS-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Readback
    // ----------------------------------------------------------------------
    assign sel_half = sel_word[{ctx_access.lane, 4'b0000} +: 16];

    always_comb begin
        prdata = '0;
        if (access && !pwrite && !err) begin
            case (region)
                cgra_pkg::region_ctx: begin
                    prdata[15:0] = sel_half;
                end
                cgra_pkg::region_ctrl: begin
                    case (reg_sel)
                        cgra_pkg::reg_run:
                            prdata[0] = run;
                        cgra_pkg::reg_loop_start:
                            prdata[cgra_pkg::CTX_ROW_BITS-1:0] = loop_cfg.loop_start;
                        cgra_pkg::reg_loop_end:
                            prdata[cgra_pkg::CTX_ROW_BITS-1:0] = loop_cfg.loop_end;
                        default:
                            prdata = '0;
                    endcase
                end
                cgra_pkg::region_status: begin
                    prdata[cgra_pkg::CTX_ROW_BITS-1:0] = sel_pc;
                end
                default: begin
                    prdata = '0;
                end
            endcase
        end
    end

endmodule

/* hdl/cgra_array.sv */
`timescale 1ns/1ps

module cgra_array #(
    parameter int NUM_TILES = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [cgra_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic [cgra_pkg::APB_DATA_WIDTH-1:0] pwdata,
    input  logic [cgra_pkg::APB_STRB_WIDTH-1:0] pstrb,
    output logic [cgra_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr
);

    cgra_pkg::ctx_access_t             ctx_access;
    cgra_pkg::loop_cfg_t               loop_cfg;
    logic [NUM_TILES-1:0]              tile_sel;
    logic                              run;
    cgra_pkg::ctx_word_t               tile_word [NUM_TILES];
    logic [cgra_pkg::CTX_ROW_BITS-1:0] tile_pc [NUM_TILES];

    // ----------------------------------------------------------------------
    // Host configuration port
    // ----------------------------------------------------------------------
    cfg_apb_slave #(
        .NUM_TILES (NUM_TILES)
    ) u_cfg (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .tile_word  (tile_word),
        .tile_pc    (tile_pc),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .ctx_access (ctx_access),
        .tile_sel   (tile_sel),
        .loop_cfg   (loop_cfg),
        .run        (run)
    );

    // ----------------------------------------------------------------------
    // Tiles
    // ----------------------------------------------------------------------
    for (genvar g = 0; g < NUM_TILES; g++) begin : g_tile
        cgra_tile u_tile (
            .clk        (clk),
            .reset      (reset),
            .ctx_access (ctx_access),
            .sel        (tile_sel[g]),
            .loop_cfg   (loop_cfg),
            .run        (run),
            .host_word  (tile_word[g]),
            .pc         (tile_pc[g])
        );
    end

endmodule

/* testbench/cgra_array_assertions.sv */
`timescale 1ns/1ps

module cgra_array_assertions #(
    parameter int NUM_TILES = 4
) (
    input logic                                clk,
    input logic                                reset,
    input logic                                psel,
    input logic                                penable,
    input logic [cgra_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input logic                                pslverr,
    input cgra_pkg::ctx_access_t               ctx_access,
    input logic [NUM_TILES-1:0]                tile_sel,
    input logic                                run,
    input logic [cgra_pkg::CTX_ROW_BITS-1:0]   tile_pc [NUM_TILES]
);

    // Error response only in ACCESS, never for the control registers
    assert property (@(posedge clk) disable iff (reset)
        pslverr |-> (psel && penable &&
                     paddr[cgra_pkg::REGION_LSB +: 2] != cgra_pkg::region_ctrl))
        else $error("pslverr high outside an ACCESS phase or on a control access");

    // A context write reaches exactly one tile and never while running
    assert property (@(posedge clk) disable iff (reset)
        ctx_access.write |-> ($onehot(tile_sel) && !run))
        else $error("context write with a bad tile select or while running");

    // Frozen program counters
    for (genvar g = 0; g < NUM_TILES; g++) begin : g_pc
        assert property (@(posedge clk) disable iff (reset) !run |=> $stable(tile_pc[g]))
            else $error("pc of tile %0d moved while run was low", g);
    end

endmodule

bind cgra_array cgra_array_assertions #(
    .NUM_TILES (NUM_TILES)
) u_assertions (
    .clk        (clk),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .paddr      (paddr),
    .pslverr    (pslverr),
    .ctx_access (ctx_access),
    .tile_sel   (tile_sel),
    .run        (run),
    .tile_pc    (tile_pc)
);

/* testbench/tb_cgra_array.sv */
`timescale 1ns/1ps

module tb_cgra_array;

    localparam int NUM_TILES = 4;
    localparam int ROWS      = 16;
    localparam int LANES     = 4;
    localparam int WAIT_MAX  = 16;
    localparam logic [4:0] JUMP_CODE = 5'b11110;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [19:0] paddr;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // Expected state of the array
    logic [63:0] model_mem [NUM_TILES][ROWS];
    int          model_pc [NUM_TILES];
    logic        model_prev_jump [NUM_TILES];
    int          loop_start;
    int          loop_end;
    int          errors;
    int          seed;
    logic [31:0] rdata;
    logic        rerr;

    cgra_array #(
        .NUM_TILES (NUM_TILES)
    ) uut (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #1ms;
        $display("Simulation stopped by the watchdog before the tests finished");
        $display("** FAIL **");
        $finish;
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    function automatic logic [19:0] addr_of(logic [1:0] region, int tile, int row, int lane);
        logic [19:0] a;
        a        = '0;
        a[19:18] = region;
        a[12:7]  = tile[5:0];
        a[6:3]   = row[3:0];
        a[2:1]   = lane[1:0];
        return a;
    endfunction

    task automatic check_equal(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Setup edge, ACCESS edge, then sample mid-cycle
    task automatic apb_transfer(logic wr, logic [19:0] addr, logic [31:0] data,
                                logic [3:0] strb, output logic [31:0] rd, output logic err);
        int waits;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        pstrb   <= strb;
        @(posedge clk);
        penable <= 1'b1;
        waits = 0;
        @(negedge clk);
        while (!pready && waits < WAIT_MAX) begin
            waits++;
            @(negedge clk);
        end
        if (!pready) begin
            errors++;
            $display("APB transfer to address %h never completed, pready stayed low", addr);
        end
        rd  = prdata;
        err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int t = 0; t < NUM_TILES; t++) begin
            model_pc[t] = 0;
            for (int r = 0; r < ROWS; r++)
                model_mem[t][r] = '0;
        end
        loop_start = 0;
        loop_end   = 0;
    endtask

    task automatic write_half(int tile, int row, int lane, logic [15:0] data, logic [1:0] strb);
        apply_ctx_write(tile, row, lane, data, strb);
        for (int b = 0; b < 2; b++)
            if (strb[b])
                model_mem[tile][row][lane*16 + b*8 +: 8] = data[b*8 +: 8];
    endtask

    task automatic apply_ctx_write(int tile, int row, int lane, logic [15:0] data,
                                   logic [1:0] strb);
        apb_transfer(1'b1, addr_of(cgra_pkg::region_ctx, tile, row, lane), {16'h0, data},
                     {2'b00, strb}, rdata, rerr);
        check_equal($sformatf("pslverr of write to tile %0d row %0d", tile, row), rerr, 0);
    endtask

    task automatic check_half(int tile, int row, int lane);
        apb_transfer(1'b0, addr_of(cgra_pkg::region_ctx, tile, row, lane), '0, '0, rdata, rerr);
        check_equal($sformatf("pslverr of read tile %0d row %0d", tile, row), rerr, 0);
        check_equal($sformatf("tile %0d row %0d lane %0d", tile, row, lane), rdata,
                    {16'h0, model_mem[tile][row][lane*16 +: 16]});
    endtask

    task automatic set_ctrl(int sel, int value);
        apb_transfer(1'b1, {2'd1, 14'd0, sel[1:0], 2'd0}, value, 4'hf, rdata, rerr);
        check_equal($sformatf("pslverr of control write %0d", sel), rerr, 0);
        if (sel == 1)
            loop_start = value;
        if (sel == 2)
            loop_end = value;
    endtask

    task automatic read_ctrl(int sel, int exp);
        apb_transfer(1'b0, {2'd1, 14'd0, sel[1:0], 2'd0}, '0, '0, rdata, rerr);
        check_equal($sformatf("control register %0d", sel), rdata, exp);
    endtask

    task automatic read_pc(int tile, output int pc);
        apb_transfer(1'b0, addr_of(cgra_pkg::region_status, tile, 0, 0), '0, '0, rdata, rerr);
        check_equal($sformatf("pslverr of pc read, tile %0d", tile), rerr, 0);
        check_equal($sformatf("pc of tile %0d", tile), rdata, model_pc[tile]);
        pc = rdata;
    endtask

    // Run for n idle cycles and step the expected pcs
    task automatic run_for(int n);
        logic [63:0] w;
        logic        jump;
        set_ctrl(0, 1);
        repeat (n) @(posedge clk);
        set_ctrl(0, 0);
        // n idle edges plus the three edges of the stopping write
        for (int t = 0; t < NUM_TILES; t++) begin
            model_prev_jump[t] = 1'b0;
            repeat (n + 3) begin
                w    = model_mem[t][model_pc[t]];
                jump = (w[34:30] == JUMP_CODE);
                if (jump && !model_prev_jump[t])
                    model_pc[t] = w[45:43];
                else if (model_pc[t] >= loop_end || model_pc[t] < loop_start)
                    model_pc[t] = loop_start;
                else
                    model_pc[t]++;
                model_prev_jump[t] = jump;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------
    task automatic test_ctx_readback();
        for (int t = 0; t < NUM_TILES; t++)
            for (int r = 0; r < ROWS; r++)
                for (int l = 0; l < LANES; l++)
                    write_half(t, r, l, 16'($random(seed)), 2'b11);
        for (int t = 0; t < NUM_TILES; t++)
            for (int r = 0; r < ROWS; r++)
                for (int l = 0; l < LANES; l++)
                    check_half(t, r, l);
    endtask

    task automatic test_byte_strobes();
        write_half(2, 5, 3, 16'h12c3, 2'b01);
        write_half(2, 5, 3, 16'hb700, 2'b10);
        write_half(0, 9, 0, 16'h5a5a, 2'b10);
        for (int l = 0; l < LANES; l++) begin
            check_half(2, 5, l);
            check_half(0, 9, l);
        end
    endtask

    task automatic test_error_responses();
        apb_transfer(1'b1, addr_of(cgra_pkg::region_ctx, NUM_TILES, 3, 1), 32'hdead, 4'h3,
                     rdata, rerr);
        check_equal("pslverr, write to missing tile", rerr, 1);
        apb_transfer(1'b0, addr_of(cgra_pkg::region_ctx, NUM_TILES, 3, 1), '0, '0, rdata, rerr);
        check_equal("pslverr, read of missing tile", rerr, 1);
        check_equal("prdata, read of missing tile", rdata, 0);
        apb_transfer(1'b0, addr_of(cgra_pkg::region_status, NUM_TILES, 0, 0), '0, '0,
                     rdata, rerr);
        check_equal("pslverr, pc read of missing tile", rerr, 1);
        apb_transfer(1'b1, addr_of(cgra_pkg::region_bad, 0, 3, 1), 32'hbeef, 4'h3, rdata, rerr);
        check_equal("pslverr, write to bad region", rerr, 1);
        apb_transfer(1'b0, addr_of(cgra_pkg::region_bad, 0, 3, 1), '0, '0, rdata, rerr);
        check_equal("pslverr, read of bad region", rerr, 1);
        check_equal("prdata, read of bad region", rdata, 0);
        // Context port is locked while running
        set_ctrl(0, 1);
        apb_transfer(1'b1, addr_of(cgra_pkg::region_ctx, 0, 3, 1), 32'h1234, 4'h3, rdata, rerr);
        check_equal("pslverr, write while running", rerr, 1);
        apb_transfer(1'b0, addr_of(cgra_pkg::region_ctx, 0, 3, 1), '0, '0, rdata, rerr);
        check_equal("pslverr, read while running", rerr, 1);
        check_equal("prdata, read while running", rdata, 0);
        set_ctrl(0, 0);
        for (int t = 0; t < NUM_TILES; t++)
            check_half(t, 3, 1);
    endtask

    task automatic test_loop_sequencing();
        int lengths [6] = '{1, 2, 3, 5, 8, 13};
        int pc;
        int pc0;
        apply_reset();
        set_ctrl(1, 2);
        set_ctrl(2, 5);
        foreach (lengths[i]) begin
            run_for(lengths[i]);
            for (int t = 0; t < NUM_TILES; t++) begin
                read_pc(t, pc);
                if (pc < 2 || pc > 5) begin
                    errors++;
                    $display("** Error @ %0t: tile %0d pc %0d outside loop", $time, t, pc);
                end
                if (t == 0)
                    pc0 = pc;
                else if (pc != pc0) begin
                    errors++;
                    $display("** Error @ %0t: tile %0d pc %0d differs from tile 0 pc %0d",
                             $time, t, pc, pc0);
                end
            end
        end
    endtask

    task automatic test_jump();
        int                  lengths [5] = '{1, 2, 4, 6, 9};
        int                  pc;
        cgra_pkg::ctx_word_t w;
        apply_reset();
        w             = '0;
        w.opcode      = cgra_pkg::op_jump;
        w.jump_target = 3'd6;
        for (int l = 0; l < LANES; l++)
            write_half(1, 2, l, w[l*16 +: 16], 2'b11);
        // Jump at the landing row follows a jump and is not taken
        w.jump_target = 3'd1;
        for (int l = 0; l < LANES; l++)
            write_half(1, 6, l, w[l*16 +: 16], 2'b11);
        set_ctrl(1, 0);
        set_ctrl(2, 3);
        foreach (lengths[i]) begin
            run_for(lengths[i]);
            read_pc(0, pc);
            if (pc > 3) begin
                errors++;
                $display("** Error @ %0t: tile 0 pc %0d outside 0 to 3", $time, pc);
            end
            read_pc(1, pc);
            if (!(pc inside {0, 1, 2, 6})) begin
                errors++;
                $display("** Error @ %0t: tile 1 pc %0d off the jump path", $time, pc);
            end
        end
    endtask

    task automatic test_ctrl_and_reset();
        int pc;
        set_ctrl(1, 7);
        set_ctrl(2, 12);
        read_ctrl(1, 7);
        read_ctrl(2, 12);
        set_ctrl(0, 1);
        read_ctrl(0, 1);
        set_ctrl(0, 0);
        read_ctrl(0, 0);
        // Still running when reset hits
        set_ctrl(0, 1);
        apply_reset();
        for (int r = 0; r < 3; r++)
            read_ctrl(r, 0);
        for (int t = 0; t < NUM_TILES; t++) begin
            read_pc(t, pc);
            for (int l = 0; l < LANES; l++)
                check_half(t, 2, l);
        end
    endtask

    initial begin
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        pstrb   = '0;
        errors  = 0;
        seed    = 32'h2ae7;
        apply_reset();
        test_ctx_readback();
        test_byte_strobes();
        test_error_responses();
        test_loop_sequencing();
        test_jump();
        test_ctrl_and_reset();
        $display("Tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* cgra_array.f */
hdl/cgra_pkg.sv
hdl/context_memory.sv
hdl/cgra_tile.sv
hdl/cfg_apb_slave.sv
hdl/cgra_array.sv
testbench/cgra_array_assertions.sv
testbench/tb_cgra_array.sv

/* Bender.yml */
package:
  name: cgra_array

sources:
  - hdl/cgra_pkg.sv
  - hdl/context_memory.sv
  - hdl/cgra_tile.sv
  - hdl/cfg_apb_slave.sv
  - hdl/cgra_array.sv
  - target: test
    files:
      - testbench/cgra_array_assertions.sv
      - testbench/tb_cgra_array.sv
